//--- filelist.f
logic/gm_video_pkg.sv
logic/gm_game_pkg.sv
logic/key_decoder.sv
logic/round_timer.sv
logic/screen_filler.sv
logic/hook_sprite.sv
logic/pixel_arbiter.sv
logic/game_control.sv
logic/gold_miner_core.sv
bench/tb_gold_miner.sv

//--- Bender.yml
package:
  name: gold_miner_core

sources:
  - logic/gm_video_pkg.sv
  - logic/gm_game_pkg.sv
  - logic/key_decoder.sv
  - logic/round_timer.sv
  - logic/screen_filler.sv
  - logic/hook_sprite.sv
  - logic/pixel_arbiter.sv
  - logic/game_control.sv
  - logic/gold_miner_core.sv
  - target: simulation
    files:
      - bench/tb_gold_miner.sv

//--- bench/tb_gold_miner.sv
`timescale 1ns/1ps

module tb_gold_miner import gm_video_pkg::*, gm_game_pkg::*;
();

	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 8;
	localparam int HOOK_W = 8;
	localparam int HOOK_H = 4;
	localparam int TICKS_PER_SECOND = 400;
	localparam int ROUND_SECONDS = 3;
	localparam int ROWS = 13;

	typedef enum logic [1:0] {SYNC_NONE, SYNC_DRAIN, SYNC_LATE, SYNC_ZERO} sync_e;
	typedef enum logic [1:0] {ACT_NONE, ACT_FILL, ACT_HOOK, ACT_OVER} act_e;

	// one stimulus row where arg is a colour for fills and a slot for hooks
	typedef struct packed
	{
		logic [7:0] scan;
		sync_e      sync;
		act_e       act;
		logic [5:0] arg;
		logic [7:0] idle;
	} row_t;

	logic CLOCK_50 = 1'b0;
	logic rst;
	logic [7:0] scan_data;
	logic scan_valid;
	seg_t hex0, hex1;
	x_t x;
	y_t y;
	colour_t colour;
	logic plot, playing, game_over;

	row_t stim [ROWS];
	logic [23:0] expect_q [$];  // {is_fill, x, y, colour}
	logic [23:0] exp_pix;
	int shown;    // count decoded from the displays
	int pending;  // 1 waits for playing, 2 for game_over
	int cycles = 0;
	int limit;
	int tens_v, ones_v, val;
	integer seed;

	gold_miner_core #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .HOOK_W(HOOK_W),
		.HOOK_H(HOOK_H), .TICKS_PER_SECOND(TICKS_PER_SECOND),
		.ROUND_SECONDS(ROUND_SECONDS)) dut (
		.CLOCK_50(CLOCK_50), .rst(rst), .scan_data(scan_data), .scan_valid(scan_valid),
		.hex0(hex0), .hex1(hex1), .x(x), .y(y), .colour(colour), .plot(plot),
		.playing(playing), .game_over(game_over));

	always #4 CLOCK_50 = ~CLOCK_50;

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// standard active-low shapes back to a digit
	function automatic int digit_of(input seg_t s);
		case (s)
			7'h40: digit_of = 0;
			7'h79: digit_of = 1;
			7'h24: digit_of = 2;
			7'h30: digit_of = 3;
			7'h19: digit_of = 4;
			7'h12: digit_of = 5;
			7'h02: digit_of = 6;
			7'h78: digit_of = 7;
			7'h00: digit_of = 8;
			7'h10: digit_of = 9;
			default: digit_of = -1;
		endcase
	endfunction

	task automatic push_fill(input colour_t c, input int status);
		for (int r = 0; r < SCREEN_H; r++)
			for (int k = 0; k < SCREEN_W; k++)
				expect_q.push_back({1'b1, x_t'(k), y_t'(r), c});
		pending = status;
	endtask

	task automatic push_hook(input int slot);
		for (int r = 0; r < HOOK_H; r++)
			for (int k = 0; k < HOOK_W; k++)
				expect_q.push_back({1'b0, x_t'(slot * HOOK_W + k), y_t'(r), HOOK_COLOUR});
	endtask

	task automatic wait_drain();
		while (expect_q.size() != 0)
			@(negedge CLOCK_50);
		if (pending == 1)
		begin
			while (!playing)
				@(negedge CLOCK_50);
			assert (shown == ROUND_SECONDS)
			else stop_with_failure($sformatf("FAIL hex count: got %h expected %h",
				shown, ROUND_SECONDS));
		end
		else if (pending == 2)
			while (!game_over)
				@(negedge CLOCK_50);
		pending = 0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		scan_data = b;
		scan_valid = 1'b1;
		@(negedge CLOCK_50);
		scan_valid = 1'b0;
	endtask

	// random filler bytes that are never a command code
	task automatic idle_bytes(input int n);
		logic [31:0] r;
		repeat (n)
		begin
			r = $random(seed);
			scan_data = r[15:8];
			scan_valid = r[0] && r[15:8] != SCAN_ENTER && r[15:8] != SCAN_DOWN;
			@(negedge CLOCK_50);
		end
		scan_valid = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		case (r.sync)
			SYNC_DRAIN: wait_drain();
			SYNC_LATE:
			begin
				wait_drain();
				while (shown != 1)
					@(negedge CLOCK_50);
				repeat (TICKS_PER_SECOND - HOOK_W * HOOK_H / 2)  // hook straddles zero
					@(negedge CLOCK_50);
			end
			SYNC_ZERO:
				while (shown != 0)
					@(negedge CLOCK_50);
			default: ;
		endcase
		case (r.act)
			ACT_FILL: push_fill(colour_t'(r.arg), 1);
			ACT_OVER: push_fill(colour_t'(r.arg), 2);
			ACT_HOOK: push_hook(int'(r.arg));
			default: ;
		endcase
		send_byte(r.scan);
		idle_bytes(int'(r.idle));
	endtask

	// pixel monitor
	always @(posedge CLOCK_50)
	begin
		if (!rst && plot)
		begin
			assert (expect_q.size() != 0)
			else stop_with_failure("a pixel was plotted while none was expected");
			exp_pix = expect_q.pop_front();
			assert (x == exp_pix[22:14])
			else stop_with_failure($sformatf("FAIL x: got %h expected %h", x, exp_pix[22:14]));
			assert (y == exp_pix[13:6])
			else stop_with_failure($sformatf("FAIL y: got %h expected %h", y, exp_pix[13:6]));
			assert (colour == exp_pix[5:0])
			else stop_with_failure($sformatf("FAIL colour: got %h expected %h",
				colour, exp_pix[5:0]));
			if (exp_pix[23])
				assert (!playing && !game_over)
				else stop_with_failure("a status level was high during a screen fill");
		end
	end

	// countdown only steps down by one or reloads from zero
	always @(posedge CLOCK_50)
	begin
		if (!rst)
		begin
			tens_v = digit_of(hex1);
			ones_v = digit_of(hex0);
			assert (tens_v >= 0 && ones_v >= 0)
			else stop_with_failure("the seven-segment outputs show no decimal digit");
			val = tens_v * 10 + ones_v;
			if (val != shown)
			begin
				assert (val == shown - 1 || (shown == 0 && val == ROUND_SECONDS))
				else stop_with_failure($sformatf("FAIL hex count: got %h expected %h",
					val, shown - 1));
				shown = val;
			end
		end
	end

	always @(posedge CLOCK_50)
	begin
		cycles++;
		if (cycles > limit)
			stop_with_failure("the run went past its cycle limit");
	end

	initial
	begin
		seed = 32'hd9408beb;
		rst = 1'b1;
		scan_data = 8'h00;
		scan_valid = 1'b0;
		shown = ROUND_SECONDS;
		pending = 0;
		stim[0] = '{SCAN_DOWN, SYNC_NONE, ACT_NONE, 6'd0, 8'd20};  // down before enter
		stim[1] = '{SCAN_ENTER, SYNC_NONE, ACT_FILL, BG_COLOUR, 8'd10};
		stim[2] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd0, 8'd12};
		stim[3] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd1, 8'd6};
		stim[4] = '{SCAN_DOWN, SYNC_NONE, ACT_NONE, 6'd0, 8'd10};  // hook still busy
		stim[5] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd2, 8'd8};
		stim[6] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd3, 8'd8};
		stim[7] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd0, 8'd8};  // wrapped slot
		stim[8] = '{SCAN_DOWN, SYNC_LATE, ACT_HOOK, 6'd1, 8'd0};
		stim[9] = '{SCAN_DOWN, SYNC_ZERO, ACT_OVER, OVER_COLOUR, 8'd10};
		stim[10] = '{SCAN_DOWN, SYNC_DRAIN, ACT_NONE, 6'd0, 8'd30};
		stim[11] = '{SCAN_ENTER, SYNC_DRAIN, ACT_FILL, BG_COLOUR, 8'd10};  // new round
		stim[12] = '{SCAN_DOWN, SYNC_DRAIN, ACT_HOOK, 6'd0, 8'd10};
		limit = ROUND_SECONDS * TICKS_PER_SECOND * 2;
		for (int i = 0; i < ROWS; i++)
		begin
			limit += 2 * int'(stim[i].idle);
			if (stim[i].act == ACT_HOOK)
				limit += HOOK_W * HOOK_H;
			else if (stim[i].act != ACT_NONE)
				limit += SCREEN_W * SCREEN_H;
		end
		repeat (2) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst = 1'b0;
		assert (!plot && !playing && !game_over)
		else stop_with_failure("plot or a status level was high after reset");
		assert (hex1 == 7'h40 && hex0 == 7'h30)
		else stop_with_failure($sformatf("FAIL hex1/hex0: got %h %h expected 40 30", hex1, hex0));
		for (int i = 0; i < ROWS; i++)
			apply_row(stim[i]);
		wait_drain();
		idle_bytes(20);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- logic/gold_miner_core.sv
`timescale 1ns/1ps

module gold_miner_core import gm_video_pkg::*, gm_game_pkg::*;
#(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int HOOK_W = 8,
	parameter int HOOK_H = 12,
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int ROUND_SECONDS = 30
)
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  logic [7:0] scan_data,
	input  logic       scan_valid,
	output seg_t       hex0,
	output seg_t       hex1,
	output x_t         x,
	output y_t         y,
	output colour_t    colour,
	output logic       plot,
	output logic       playing,
	output logic       game_over
);

	logic enter, down;
	logic timer_load, time_done;
	logic fill_start, fill_done, hook_start, hook_done;
	colour_t fill_colour;
	x_t hook_x;

	// painter side of the pixel bus
	logic fill_req, fill_ack, fill_pwr;
	logic hook_req, hook_ack, hook_pwr;
	x_t fill_px, hook_px;
	y_t fill_py, hook_py;
	colour_t fill_pcolour, hook_pcolour;

	key_decoder keys (.CLOCK_50(CLOCK_50), .rst(rst), .scan_data(scan_data),
		.scan_valid(scan_valid), .enter(enter), .down(down));

	round_timer #(.TICKS_PER_SECOND(TICKS_PER_SECOND), .ROUND_SECONDS(ROUND_SECONDS)) timer (
		.CLOCK_50(CLOCK_50), .rst(rst), .timer_load(timer_load), .time_done(time_done),
		.hex0(hex0), .hex1(hex1));

	game_control #(.SCREEN_W(SCREEN_W), .HOOK_W(HOOK_W)) control (
		.CLOCK_50(CLOCK_50), .rst(rst), .enter(enter), .down(down), .time_done(time_done),
		.fill_done(fill_done), .hook_done(hook_done), .timer_load(timer_load),
		.fill_start(fill_start), .fill_colour(fill_colour), .hook_start(hook_start),
		.hook_x(hook_x), .playing(playing), .game_over(game_over));

	screen_filler #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) filler (
		.CLOCK_50(CLOCK_50), .rst(rst), .fill_start(fill_start), .fill_colour(fill_colour),
		.fill_done(fill_done), .req(fill_req), .ack(fill_ack), .px(fill_px), .py(fill_py),
		.pcolour(fill_pcolour), .pwr(fill_pwr));

	hook_sprite #(.HOOK_W(HOOK_W), .HOOK_H(HOOK_H)) hook (
		.CLOCK_50(CLOCK_50), .rst(rst), .hook_start(hook_start), .hook_x(hook_x),
		.hook_done(hook_done), .req(hook_req), .ack(hook_ack), .px(hook_px), .py(hook_py),
		.pcolour(hook_pcolour), .pwr(hook_pwr));

	pixel_arbiter arbiter (.CLOCK_50(CLOCK_50), .rst(rst),
		.fill_req(fill_req), .fill_ack(fill_ack), .hook_req(hook_req), .hook_ack(hook_ack),
		.fill_px(fill_px), .fill_py(fill_py), .fill_pcolour(fill_pcolour), .fill_pwr(fill_pwr),
		.hook_px(hook_px), .hook_py(hook_py), .hook_pcolour(hook_pcolour), .hook_pwr(hook_pwr),
		.x(x), .y(y), .colour(colour), .plot(plot));

endmodule

//--- logic/game_control.sv
`timescale 1ns/1ps

module game_control import gm_video_pkg::*, gm_game_pkg::*;
#(
	parameter int SCREEN_W = 320,
	parameter int HOOK_W = 8
)
(
	input  logic    CLOCK_50,
	input  logic    rst,
	input  logic    enter,
	input  logic    down,
	input  logic    time_done,
	input  logic    fill_done,
	input  logic    hook_done,
	output logic    timer_load,
	output logic    fill_start,
	output colour_t fill_colour,
	output logic    hook_start,
	output x_t      hook_x,
	output logic    playing,
	output logic    game_over
);

	localparam int SLOTS = SCREEN_W / HOOK_W;
	localparam int SB = $clog2(SLOTS + 1);

	game_state_e state;
	logic [SB-1:0] slot;  // next hook column
	logic hook_busy;
	logic start_round;
	logic go_over;
	logic go_hook;

	// enter in game over only counts once the red fill is finished
	assign start_round = enter && (state == S_IDLE || (state == S_OVER && game_over));
	assign go_over = (state == S_PLAY) && time_done;
	assign go_hook = (state == S_PLAY) && down && !hook_busy && !time_done;
	assign playing = (state == S_PLAY);

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			timer_load <= 1'b0;
			fill_start <= 1'b0;
			hook_start <= 1'b0;
			hook_busy <= 1'b0;
			game_over <= 1'b0;
			slot <= '0;
		end
		else
		begin
			timer_load <= start_round;
			fill_start <= start_round || go_over;
			hook_start <= go_hook;
			if (hook_done)
				hook_busy <= 1'b0;
			if (start_round)
			begin
				state <= S_FILL;
				slot <= '0;
				game_over <= 1'b0;
			end
			else if (state == S_FILL && fill_done)
				state <= S_PLAY;
			else if (go_over)
				state <= S_OVER;  // hook may still be painting
			else if (go_hook)
			begin
				hook_busy <= 1'b1;
				slot <= (slot == SB'(SLOTS - 1)) ? '0 : slot + 1'b1;
			end
			else if (state == S_OVER && fill_done)
				game_over <= 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (start_round)
			fill_colour <= BG_COLOUR;
		else if (go_over)
			fill_colour <= OVER_COLOUR;
		if (go_hook)
			hook_x <= x_t'(slot * HOOK_W);
	end

endmodule

//--- logic/pixel_arbiter.sv
`timescale 1ns/1ps

module pixel_arbiter import gm_video_pkg::*;
(
	input  logic    CLOCK_50,
	input  logic    rst,
	input  logic    fill_req,
	output logic    fill_ack,
	input  logic    hook_req,
	output logic    hook_ack,
	input  x_t      fill_px,
	input  y_t      fill_py,
	input  colour_t fill_pcolour,
	input  logic    fill_pwr,
	input  x_t      hook_px,
	input  y_t      hook_py,
	input  colour_t hook_pcolour,
	input  logic    hook_pwr,
	output x_t      x,
	output y_t      y,
	output colour_t colour,
	output logic    plot
);

	grant_e owner;
	x_t sel_x;
	y_t sel_y;
	colour_t sel_colour;
	logic sel_pwr;

	// fill wins when both ask, no preemption
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			owner <= GRANT_NONE;
		else
			case (owner)
				GRANT_NONE:
					if (fill_req)
						owner <= GRANT_FILL;
					else if (hook_req)
						owner <= GRANT_HOOK;
				GRANT_FILL:
					if (!fill_req)
						owner <= GRANT_NONE;
				GRANT_HOOK:
					if (!hook_req)
						owner <= GRANT_NONE;
				default: owner <= GRANT_NONE;
			endcase
	end

	assign fill_ack = (owner == GRANT_FILL);
	assign hook_ack = (owner == GRANT_HOOK);

	always_comb
	begin
		sel_x = fill_px;
		sel_y = fill_py;
		sel_colour = fill_pcolour;
		sel_pwr = 1'b0;  // idle bus never plots
		if (owner == GRANT_FILL)
			sel_pwr = fill_pwr;
		else if (owner == GRANT_HOOK)
		begin
			sel_x = hook_px;
			sel_y = hook_py;
			sel_colour = hook_pcolour;
			sel_pwr = hook_pwr;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			plot <= 1'b0;
		else
			plot <= sel_pwr;
	end

	always_ff @(posedge CLOCK_50)
	begin
		x <= sel_x;
		y <= sel_y;
		colour <= sel_colour;
	end

endmodule

//--- logic/hook_sprite.sv
`timescale 1ns/1ps

module hook_sprite import gm_video_pkg::*;
#(
	parameter int HOOK_W = 8,
	parameter int HOOK_H = 12
)
(
	input  logic    CLOCK_50,
	input  logic    rst,
	input  logic    hook_start,
	input  x_t      hook_x,
	output logic    hook_done,
	output logic    req,
	input  logic    ack,
	output x_t      px,
	output y_t      py,
	output colour_t pcolour,
	output logic    pwr
);

	x_t x0_q;  // column origin
	x_t col;   // offset inside the sprite
	y_t row;
	logic busy;
	logic last_pixel;
	logic launch;

	assign launch = hook_start && !busy;
	assign last_pixel = (col == x_t'(HOOK_W - 1)) && (row == y_t'(HOOK_H - 1));

	assign pwr = req && ack;
	assign px = x0_q + col;
	assign py = row;  // sprite sits on the top rows
	assign pcolour = HOOK_COLOUR;
	assign hook_done = busy && !req && !ack;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			req <= 1'b0;
		end
		else if (launch)
		begin
			busy <= 1'b1;
			req <= 1'b1;
		end
		else if (pwr && last_pixel)
			req <= 1'b0;  // release after the last write
		else if (hook_done)
			busy <= 1'b0;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (launch)
		begin
			x0_q <= hook_x;
			col <= '0;
			row <= '0;
		end
		else if (pwr)
		begin
			if (col == x_t'(HOOK_W - 1))
			begin
				col <= '0;
				row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

endmodule

//--- logic/screen_filler.sv
`timescale 1ns/1ps

module screen_filler import gm_video_pkg::*;
#(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
)
(
	input  logic    CLOCK_50,
	input  logic    rst,
	input  logic    fill_start,
	input  colour_t fill_colour,
	output logic    fill_done,
	output logic    req,
	input  logic    ack,
	output x_t      px,
	output y_t      py,
	output colour_t pcolour,
	output logic    pwr
);

	x_t cx;
	y_t cy;
	colour_t colour_q;
	logic busy;  // start to done
	logic last_pixel;
	logic launch;

	assign launch = fill_start && !busy;
	assign last_pixel = (cx == x_t'(SCREEN_W - 1)) && (cy == y_t'(SCREEN_H - 1));

	assign pwr = req && ack;  // one pixel per granted cycle
	assign px = cx;
	assign py = cy;
	assign pcolour = colour_q;
	assign fill_done = busy && !req && !ack;  // arbiter has let go

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			req <= 1'b0;
		end
		else if (launch)
		begin
			busy <= 1'b1;
			req <= 1'b1;
		end
		else if (pwr && last_pixel)
			req <= 1'b0;
		else if (fill_done)
			busy <= 1'b0;
	end

	// raster walk, left to right then down
	always_ff @(posedge CLOCK_50)
	begin
		if (launch)
		begin
			cx <= '0;
			cy <= '0;
			colour_q <= fill_colour;
		end
		else if (pwr)
		begin
			if (cx == x_t'(SCREEN_W - 1))
			begin
				cx <= '0;
				cy <= cy + 1'b1;
			end
			else
				cx <= cx + 1'b1;
		end
	end

endmodule

//--- logic/round_timer.sv
`timescale 1ns/1ps

module round_timer import gm_game_pkg::*;
#(
	parameter int TICKS_PER_SECOND = 50_000_000,
	parameter int ROUND_SECONDS = 30
)
(
	input  logic CLOCK_50,
	input  logic rst,
	input  logic timer_load,
	output logic time_done,
	output seg_t hex0,
	output seg_t hex1
);

	localparam int PW = $clog2(TICKS_PER_SECOND + 1);
	localparam digit_t INIT_TENS = digit_t'(ROUND_SECONDS / 10);
	localparam digit_t INIT_ONES = digit_t'(ROUND_SECONDS % 10);

	logic [PW-1:0] tick_cnt;  // prescaler
	logic running;
	logic second_tick;
	digit_t tens;
	digit_t ones;

	function automatic seg_t seg_of(input digit_t d);
		case (d)
			4'd0: seg_of = 7'b1000000;
			4'd1: seg_of = 7'b1111001;
			4'd2: seg_of = 7'b0100100;
			4'd3: seg_of = 7'b0110000;
			4'd4: seg_of = 7'b0011001;
			4'd5: seg_of = 7'b0010010;
			4'd6: seg_of = 7'b0000010;
			4'd7: seg_of = 7'b1111000;
			4'd8: seg_of = 7'b0000000;
			4'd9: seg_of = 7'b0010000;
			default: seg_of = 7'b1111111;  // blank
		endcase
	endfunction

	assign second_tick = running && (tick_cnt == PW'(TICKS_PER_SECOND - 1));

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			tens <= INIT_TENS;
			ones <= INIT_ONES;
			running <= 1'b0;
			tick_cnt <= '0;
			time_done <= 1'b0;
		end
		else
		begin
			time_done <= 1'b0;
			if (timer_load)
			begin
				tens <= INIT_TENS;
				ones <= INIT_ONES;
				running <= 1'b1;
				tick_cnt <= '0;
			end
			else if (second_tick)
			begin
				tick_cnt <= '0;
				if (ones == 4'd0)  // borrow from tens
				begin
					ones <= 4'd9;
					tens <= tens - 1'b1;
				end
				else
					ones <= ones - 1'b1;
				// last second, stop at 00
				if (tens == 4'd0 && ones == 4'd1)
				begin
					running <= 1'b0;
					time_done <= 1'b1;
				end
			end
			else if (running)
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign hex0 = seg_of(ones);
	assign hex1 = seg_of(tens);

endmodule

//--- logic/key_decoder.sv
`timescale 1ns/1ps

module key_decoder import gm_game_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  logic [7:0] scan_data,
	input  logic       scan_valid,
	output logic       enter,
	output logic       down
);

	logic [7:0] byte_q;  // last byte seen
	logic valid_q;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= scan_valid;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (scan_valid)
			byte_q <= scan_data;
	end

	// valid_q is only high for one cycle per byte
	assign enter = valid_q && (byte_q == SCAN_ENTER);
	assign down = valid_q && (byte_q == SCAN_DOWN);

endmodule

//--- logic/gm_game_pkg.sv
package gm_game_pkg;

	// round sequencing
	typedef enum logic [1:0]
	{
		S_IDLE,  // waiting for first enter
		S_FILL,  // clearing the screen
		S_PLAY,
		S_OVER
	} game_state_e;

	// ps/2 set 2 make codes
	localparam logic [7:0] SCAN_ENTER = 8'h5A;
	localparam logic [7:0] SCAN_DOWN = 8'h1B;  // 's' key drops the hook

	// one bcd digit of the countdown
	typedef logic [3:0] digit_t;

	// active low, bit 0 is segment a, bit 6 is g
	typedef logic [6:0] seg_t;

endpackage

//--- logic/gm_video_pkg.sv
package gm_video_pkg;

	// pixel colour, two bits each for r, g and b
	typedef logic [5:0] colour_t;

	// 320x240 frame coordinates
	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;

	// cleared screen, dark earth
	localparam colour_t BG_COLOUR = 6'h04;

	localparam colour_t HOOK_COLOUR = 6'h3F;  // white hook

	localparam colour_t OVER_COLOUR = 6'h30;  // red screen when time runs out

	// current owner of the shared pixel bus
	typedef enum logic [1:0]
	{
		GRANT_NONE,
		GRANT_FILL,
		GRANT_HOOK
	} grant_e;

endpackage
